/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the undo log testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module undo_log_tb -f undo_log_top.f -o undo_log_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/undo_log_sim 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qxF "Simulation completed successfully"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* undo_log_ack.sv */
module undo_log_ack (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     start_valid,
   input  undo_log_pkg::slot_t      start_slot,
   input  undo_log_pkg::entry_cnt_t start_count,
   input  logic                     wr_done,
   input  logic                     mem_bvalid,
   output logic                     restore_done_valid,
   output undo_log_pkg::slot_t      restore_done_slot,
   input  logic                     restore_done_ready,
   output logic                     done_pending,
   output logic                     done_clear
);
   import undo_log_pkg::*;

   entry_cnt_t remaining_q;
   entry_cnt_t outstanding_q;
   slot_t      slot_q;
   logic       done_q;
   logic       pending_q;
   logic       handshake;

   assign handshake          = done_q && restore_done_ready;
   assign done_clear         = handshake;
   assign restore_done_valid = done_q;
   assign restore_done_slot  = slot_q;
   assign done_pending       = pending_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining_q <= '0;
         done_q      <= 1'b0;
         pending_q   <= 1'b0;
      end else begin
         if (start_valid) begin
            remaining_q <= start_count;
            pending_q   <= 1'b1;
            done_q      <= (start_count == '0);
         end else if (mem_bvalid) begin
            remaining_q <= remaining_q - 1'b1;
            if (remaining_q == entry_cnt_t'(1)) begin
               done_q <= 1'b1;   // last expected ack.
            end
         end
         if (handshake) begin
            done_q    <= 1'b0;
            pending_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_valid) begin
         slot_q <= start_slot;
      end
   end

   // writes issued but not yet acknowledged.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         outstanding_q <= '0;
      end else begin
         case ({wr_done, mem_bvalid})
            2'b10:   outstanding_q <= outstanding_q + 1'b1;
            2'b01:   outstanding_q <= outstanding_q - 1'b1;
            default: outstanding_q <= outstanding_q;
         endcase
      end
   end

   a_no_stray_ack: assert property (@(posedge clk) disable iff (!rstn)
      mem_bvalid |-> (outstanding_q != '0) && (remaining_q != '0));

   a_done_hold: assert property (@(posedge clk) disable iff (!rstn)
      restore_done_valid && !restore_done_ready
         |=> restore_done_valid && $stable(restore_done_slot));

endmodule

/* undo_log_capture.sv */
`include "undo_log_config.svh"

module undo_log_capture (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic [`UL_N_THREADS-1:0]                   log_valid,
   input  undo_log_pkg::log_req_t [`UL_N_THREADS-1:0] log_req,
   output logic [`UL_N_THREADS-1:0]                   log_ready,
   input  logic                                       commit_valid,
   input  undo_log_pkg::slot_t                        commit_slot,
   input  logic                                       done_clear,
   input  undo_log_pkg::slot_t                        done_slot,
   input  undo_log_pkg::slot_t                        rd_slot,
   input  undo_log_pkg::entry_id_t                    rd_id,
   output undo_log_pkg::log_entry_t                   rd_entry,
   output undo_log_pkg::entry_cnt_t                   rd_count
);
   import undo_log_pkg::*;

   localparam int SEL_W = $clog2(`UL_N_THREADS);

   logic [SEL_W-1:0] sel;
   logic             accept;
   log_req_t         sel_req;
   log_entry_t       store [`UL_N_SLOTS][`UL_N_ENTRIES];
   entry_cnt_t       count_q [`UL_N_SLOTS];

   // lowest valid thread wins.
   always_comb begin
      sel = '0;
      for (int i = `UL_N_THREADS - 1; i >= 0; i--) begin
         if (log_valid[i]) begin
            sel = SEL_W'(i);
         end
      end
   end

   assign accept  = |log_valid;   // selected thread is always ready.
   assign sel_req = log_req[sel];

   for (genvar t = 0; t < `UL_N_THREADS; t++) begin : g_ready
      assign log_ready[t] = accept && (sel == SEL_W'(t));
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         store[sel_req.slot][sel_req.id] <= sel_req.entry;
      end
      rd_entry <= store[rd_slot][rd_id];   // registered read port.
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int s = 0; s < `UL_N_SLOTS; s++) begin
            count_q[s] <= '0;
         end
      end else begin
         if (accept) begin
            count_q[sel_req.slot] <= entry_cnt_t'(sel_req.id) + 1'b1;   // last id marks the count.
         end
         if (commit_valid) begin
            count_q[commit_slot] <= '0;
         end
         if (done_clear) begin
            count_q[done_slot] <= '0;
         end
      end
   end

   assign rd_count = count_q[rd_slot];

   // the restored slot is wiped on the done handshake, so a new entry for it would be lost.
   a_log_not_restoring: assert property (@(posedge clk) disable iff (!rstn)
      accept && done_clear |-> sel_req.slot != done_slot);

endmodule

/* undo_log_config.svh */
`ifndef UNDO_LOG_CONFIG_SVH
`define UNDO_LOG_CONFIG_SVH

`define UL_N_THREADS   4
`define UL_LOG_SLOTS   3
`define UL_LOG_ENTRIES 2
`define UL_ADDR_W      32
`define UL_DATA_W      32

// derived sizes of the log storage.
`define UL_N_SLOTS     (1 << `UL_LOG_SLOTS)
`define UL_N_ENTRIES   (1 << `UL_LOG_ENTRIES)

`endif

/* undo_log_pkg.sv */
`include "undo_log_config.svh"

package undo_log_pkg;

   typedef logic [`UL_LOG_SLOTS-1:0]   slot_t;       // commit-queue slot.
   typedef logic [`UL_LOG_ENTRIES-1:0] entry_id_t;   // entry within a slot.
   typedef logic [`UL_LOG_ENTRIES:0]   entry_cnt_t;  // zero up to a full slot.

   typedef struct packed {
      logic [`UL_ADDR_W-1:0] addr;
      logic [`UL_DATA_W-1:0] data;   // old value to put back.
   } log_entry_t;

   typedef struct packed {
      log_entry_t entry;
      entry_id_t  id;
      slot_t      slot;
   } log_req_t;

   typedef struct packed {
      logic [`UL_ADDR_W-1:0] addr;
      logic [`UL_DATA_W-1:0] data;
   } mem_write_t;

endpackage

/* undo_log_restore.sv */
module undo_log_restore (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     restore_valid,
   input  undo_log_pkg::slot_t      restore_slot,
   output logic                     restore_ready,
   input  logic                     done_pending,
   output undo_log_pkg::slot_t      rd_slot,
   output undo_log_pkg::entry_id_t  rd_id,
   input  undo_log_pkg::log_entry_t rd_entry,
   input  undo_log_pkg::entry_cnt_t rd_count,
   output logic                     mem_wvalid,
   output undo_log_pkg::mem_write_t mem_write,
   input  logic                     mem_wready,
   output logic                     start_valid,
   output undo_log_pkg::slot_t      start_slot,
   output undo_log_pkg::entry_cnt_t start_count,
   output logic                     wr_done
);
   import undo_log_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE
   } state_t;

   state_t     state_q;
   slot_t      slot_q;
   entry_cnt_t cnt_q;
   entry_id_t  id_q;
   logic       accept;
   logic       last;

   assign restore_ready = (state_q == ST_IDLE) && !done_pending;
   assign accept        = restore_valid && restore_ready;

   assign start_valid = accept;
   assign start_slot  = restore_slot;
   assign start_count = rd_count;

   // while idle the read port follows the request so its count is ready at accept.
   assign rd_slot = (state_q == ST_IDLE) ? restore_slot : slot_q;
   assign rd_id   = id_q;

   assign mem_wvalid = (state_q == ST_WRITE);
   assign wr_done    = mem_wvalid && mem_wready;
   assign last       = (entry_cnt_t'(id_q) + 1'b1) == cnt_q;

   always_comb begin
      mem_write.addr = rd_entry.addr;
      mem_write.data = rd_entry.data;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= ST_IDLE;
         id_q    <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               id_q <= '0;
               if (accept && (rd_count != '0)) begin
                  state_q <= ST_READ;   // empty slot goes straight to done.
               end
            end
            ST_READ: begin
               state_q <= ST_WRITE;   // entry lands on rd_entry.
            end
            ST_WRITE: begin
               if (mem_wready) begin
                  if (last) begin
                     state_q <= ST_IDLE;
                  end else begin
                     id_q    <= id_q + 1'b1;
                     state_q <= ST_READ;
                  end
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         slot_q <= restore_slot;
         cnt_q  <= rd_count;
      end
   end

   // the payload comes from the capture read port, which must hold it under back-pressure.
   a_write_stable: assert property (@(posedge clk) disable iff (!rstn)
      mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_write));

endmodule

/* undo_log_tb.sv */
`include "undo_log_config.svh"

module undo_log_tb;
   import undo_log_pkg::*;

   localparam int N_THREADS = `UL_N_THREADS;
   localparam int N_SLOTS   = `UL_N_SLOTS;
   localparam int N_ENTRIES = `UL_N_ENTRIES;
   localparam int ROUNDS    = 40;

   logic                     clk = 1'b0;
   logic                     rstn;
   logic [N_THREADS-1:0]     log_valid;
   log_req_t [N_THREADS-1:0] log_req;
   logic [N_THREADS-1:0]     log_ready;
   logic                     commit_valid;
   slot_t                    commit_slot;
   logic                     restore_valid;
   slot_t                    restore_slot;
   logic                     restore_ready;
   logic                     mem_wvalid;
   mem_write_t               mem_write;
   logic                     mem_wready = 1'b0;
   logic                     mem_bvalid = 1'b0;
   logic                     restore_done_valid;
   slot_t                    restore_done_slot;
   logic                     restore_done_ready;

   integer     seed = 32'h86d9;
   int         cyc = 0;
   int         last_due = 0;
   int         ack_cnt = 0;
   int         last_ack_cyc = 0;
   int         ack_due [$];
   mem_write_t wr_q [$];
   log_entry_t model_ent [N_SLOTS][N_ENTRIES];
   entry_cnt_t model_cnt [N_SLOTS];

   always #4 clk = ~clk;

   undo_log_top DUT (
      .clk                (clk),
      .rstn               (rstn),
      .log_valid          (log_valid),
      .log_req            (log_req),
      .log_ready          (log_ready),
      .commit_valid       (commit_valid),
      .commit_slot        (commit_slot),
      .restore_valid      (restore_valid),
      .restore_slot       (restore_slot),
      .restore_ready      (restore_ready),
      .mem_wvalid         (mem_wvalid),
      .mem_write          (mem_write),
      .mem_wready         (mem_wready),
      .mem_bvalid         (mem_bvalid),
      .restore_done_valid (restore_done_valid),
      .restore_done_slot  (restore_done_slot),
      .restore_done_ready (restore_done_ready)
   );

   function automatic int pick(input int range);
      pick = {$random(seed)} % range;
   endfunction

   function automatic int lowest_thread(input logic [N_THREADS-1:0] mask);
      for (int i = 0; i < N_THREADS; i++) begin
         if (mask[i]) begin
            return i;
         end
      end
      return 0;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
      end
   endtask

   // memory side, sampled at the edge that ends each cycle.
   always @(posedge clk) begin
      int due;
      if (!rstn) begin
         mem_wready <= 1'b0;
         mem_bvalid <= 1'b0;
      end else begin
         if (mem_wvalid && mem_wready) begin
            wr_q.push_back(mem_write);
            due = cyc + 1 + pick(6);   // ack 1 to 6 cycles later.
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            ack_due.push_back(due);
         end
         if (mem_bvalid) begin
            ack_cnt++;
            last_ack_cyc = cyc;
         end
         mem_wready <= (pick(4) != 0);
         if (ack_due.size() != 0 && ack_due[0] <= cyc + 1) begin
            mem_bvalid <= 1'b1;
            void'(ack_due.pop_front());
         end else begin
            mem_bvalid <= 1'b0;
         end
      end
      cyc <= cyc + 1;
   end

   task automatic log_batch(input logic [N_THREADS-1:0] mask,
                            input log_req_t [N_THREADS-1:0] reqs);
      int win;
      @(posedge clk);
      log_valid <= mask;
      log_req   <= reqs;
      while (mask != '0) begin
         @(negedge clk);
         win = lowest_thread(mask);
         compare("log_ready", 64'(1) << win, log_ready);
         model_ent[reqs[win].slot][reqs[win].id] = reqs[win].entry;
         model_cnt[reqs[win].slot] = entry_cnt_t'(reqs[win].id) + 1'b1;
         mask[win] = 1'b0;
         @(posedge clk);
         log_valid <= mask;
      end
      @(negedge clk);
   endtask

   task automatic pulse_commit(input slot_t s);
      @(posedge clk);
      commit_valid <= 1'b1;
      commit_slot  <= s;
      @(posedge clk);
      commit_valid <= 1'b0;
      model_cnt[s] = '0;
      @(negedge clk);
   endtask

   task automatic restore_and_check(input slot_t s);
      int   n;
      int   guard;
      int   accept_cyc;
      int   exp_cyc;
      logic ready_next;
      n = model_cnt[s];
      guard = 0;
      @(negedge clk);
      while (!restore_ready) begin
         guard++;
         if (guard > 50) begin
            abort_run("restore_ready stayed low while the engine should be idle");
         end
         @(negedge clk);
      end
      @(posedge clk);
      restore_valid <= 1'b1;
      restore_slot  <= s;
      @(negedge clk);
      compare("restore accept", 1, restore_ready);
      accept_cyc = cyc;
      wr_q.delete();
      ack_cnt = 0;
      @(posedge clk);
      restore_valid <= 1'b0;
      guard = 0;
      @(negedge clk);
      while (!restore_done_valid) begin
         compare("restore_ready while busy", 0, restore_ready);
         guard++;
         if (guard > 200) begin
            abort_run("restore done never arrived");
         end
         @(negedge clk);
      end
      exp_cyc = (n == 0) ? accept_cyc + 1 : last_ack_cyc + 1;
      compare("acks before done", n, ack_cnt);
      compare("done cycle", exp_cyc, cyc);
      compare("write count", n, wr_q.size());
      for (int i = 0; i < n; i++) begin
         compare($sformatf("write %0d of slot %0d", i, s), model_ent[s][i], wr_q[i]);
      end
      guard = 0;
      do begin
         ready_next = (pick(3) == 0);
         @(posedge clk);
         restore_done_ready <= ready_next;
         @(negedge clk);
         compare("done held", 1, restore_done_valid);
         compare("done slot", s, restore_done_slot);
         compare("restore_ready while done", 0, restore_ready);
         guard++;
         if (guard > 100) begin
            abort_run("restore done was never accepted");
         end
      end while (!restore_done_ready);
      @(posedge clk);
      restore_done_ready <= 1'b0;
      @(negedge clk);
      compare("done after handshake", 0, restore_done_valid);
      compare("restore_ready after done", 1, restore_ready);
      model_cnt[s] = '0;   // slot is wiped on the done handshake.
   endtask

   initial begin
      log_req_t [N_THREADS-1:0] reqs;
      logic [N_THREADS-1:0]     mask;
      slot_t                    s;
      int                       n;
      rstn               = 1'b0;
      log_valid          = '0;
      log_req            = '0;
      commit_valid       = 1'b0;
      commit_slot        = '0;
      restore_valid      = 1'b0;
      restore_slot       = '0;
      restore_done_ready = 1'b0;
      for (int p = 0; p < N_SLOTS; p++) begin
         model_cnt[p] = '0;
      end
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      compare("reset log_ready", 0, log_ready);
      compare("reset mem_wvalid", 0, mem_wvalid);
      compare("reset done", 0, restore_done_valid);
      compare("reset restore_ready", 1, restore_ready);

      // fill every cell so later restores read known data.
      for (int p = 0; p < N_SLOTS; p++) begin
         for (int t = 0; t < N_THREADS; t++) begin
            reqs[t].slot       = slot_t'(p);
            reqs[t].id         = entry_id_t'(t);
            reqs[t].entry.addr = $random(seed);
            reqs[t].entry.data = $random(seed);
         end
         log_batch('1, reqs);
      end
      for (int p = 0; p < N_SLOTS; p++) begin
         restore_and_check(slot_t'(p));
      end

      log_batch('1, reqs);
      pulse_commit(reqs[0].slot);   // a full slot that is committed restores empty.
      restore_and_check(reqs[0].slot);

      for (int r = 0; r < ROUNDS; r++) begin
         s    = slot_t'(pick(N_SLOTS));
         n    = pick(N_THREADS + 1);
         mask = '0;
         for (int t = 0; t < N_THREADS; t++) begin
            reqs[t].entry.addr = $random(seed);
            reqs[t].entry.data = $random(seed);
            if (t < n) begin
               mask[t]     = 1'b1;
               reqs[t].slot = s;
               reqs[t].id   = entry_id_t'(t);
            end else begin
               mask[t]      = (pick(2) != 0);
               reqs[t].slot = slot_t'(pick(N_SLOTS));
               reqs[t].id   = entry_id_t'(pick(N_ENTRIES));
            end
         end
         log_batch(mask, reqs);
         if (pick(4) == 0) begin
            pulse_commit(slot_t'(pick(N_SLOTS)));
         end
         if (pick(2) != 0) begin
            s = slot_t'(pick(N_SLOTS));
         end
         restore_and_check(s);
         if (pick(3) == 0) begin
            restore_and_check(s);   // same slot again, now empty.
         end
      end

      repeat (2) @(negedge clk);
      if (ack_due.size() == 0 && !mem_wvalid) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         abort_run("memory traffic was left over at the end of the test");
      end
   end

endmodule

/* undo_log_top.f */
+incdir+.
undo_log_pkg.sv
undo_log_capture.sv
undo_log_restore.sv
undo_log_ack.sv
undo_log_top.sv
undo_log_tb.sv

/* undo_log_top.sv */
`include "undo_log_config.svh"

module undo_log_top (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic [`UL_N_THREADS-1:0]                   log_valid,
   input  undo_log_pkg::log_req_t [`UL_N_THREADS-1:0] log_req,
   output logic [`UL_N_THREADS-1:0]                   log_ready,
   input  logic                                       commit_valid,
   input  undo_log_pkg::slot_t                        commit_slot,
   input  logic                                       restore_valid,
   input  undo_log_pkg::slot_t                        restore_slot,
   output logic                                       restore_ready,
   output logic                                       mem_wvalid,
   output undo_log_pkg::mem_write_t                   mem_write,
   input  logic                                       mem_wready,
   input  logic                                       mem_bvalid,
   output logic                                       restore_done_valid,
   output undo_log_pkg::slot_t                        restore_done_slot,
   input  logic                                       restore_done_ready
);
   import undo_log_pkg::*;

   slot_t      rd_slot;
   entry_id_t  rd_id;
   log_entry_t rd_entry;
   entry_cnt_t rd_count;
   logic       start_valid;
   slot_t      start_slot;
   entry_cnt_t start_count;
   logic       wr_done;
   logic       done_pending;
   logic       done_clear;

   undo_log_capture u_capture (
      .clk          (clk),
      .rstn         (rstn),
      .log_valid    (log_valid),
      .log_req      (log_req),
      .log_ready    (log_ready),
      .commit_valid (commit_valid),
      .commit_slot  (commit_slot),
      .done_clear   (done_clear),
      .done_slot    (restore_done_slot),
      .rd_slot      (rd_slot),
      .rd_id        (rd_id),
      .rd_entry     (rd_entry),
      .rd_count     (rd_count)
   );

   undo_log_restore u_restore (
      .clk           (clk),
      .rstn          (rstn),
      .restore_valid (restore_valid),
      .restore_slot  (restore_slot),
      .restore_ready (restore_ready),
      .done_pending  (done_pending),
      .rd_slot       (rd_slot),
      .rd_id         (rd_id),
      .rd_entry      (rd_entry),
      .rd_count      (rd_count),
      .mem_wvalid    (mem_wvalid),
      .mem_write     (mem_write),
      .mem_wready    (mem_wready),
      .start_valid   (start_valid),
      .start_slot    (start_slot),
      .start_count   (start_count),
      .wr_done       (wr_done)
   );

   undo_log_ack u_ack (
      .clk                (clk),
      .rstn               (rstn),
      .start_valid        (start_valid),
      .start_slot         (start_slot),
      .start_count        (start_count),
      .wr_done            (wr_done),
      .mem_bvalid         (mem_bvalid),
      .restore_done_valid (restore_done_valid),
      .restore_done_slot  (restore_done_slot),
      .restore_done_ready (restore_done_ready),
      .done_pending       (done_pending),
      .done_clear         (done_clear)
   );

endmodule
